/* all.f */
design/switch_pkg.sv
design/buf_wr_if.sv
design/buf_rd_if.sv
design/rr_arbiter.sv
design/wr_frontend.sv
design/rd_frontend.sv
design/packet_buffer.sv
design/switch_top.sv
testbench/switch_chk.sv
testbench/tb_switch.sv

/* Makefile */
TOP = tb_switch

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

obj_dir/V$(TOP): all.f $(wildcard design/*.sv testbench/*.sv)
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o V$(TOP)

sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* testbench/tb_switch.sv */
`timescale 1ns/100ps

module tb_switch;
    import switch_pkg::*;

    localparam int NUM_PKTS = 60;
    localparam int TIMEOUT  = NUM_PKTS * N_PORTS * MAX_WORDS * 8;

    logic                       clk;
    logic                       rst_n;
    logic [N_PORTS-1:0]         wr_sop;
    logic [N_PORTS-1:0]         wr_eop;
    logic [N_PORTS-1:0]         wr_vld;
    word_t [N_PORTS-1:0]        wr_data;
    logic [N_PORTS-1:0]         wr_busy;
    logic                       full;
    logic [N_PORTS-1:0]         ready;
    logic [N_PORTS-1:0]         rd_sop;
    logic [N_PORTS-1:0]         rd_eop;
    logic [N_PORTS-1:0]         rd_vld;
    word_t [N_PORTS-1:0]        rd_data;

    // reference model per output and source
    word_t exp_words [N_PORTS][N_PORTS][$];
    int    exp_len   [N_PORTS][N_PORTS][$];

    logic  in_pkt  [N_PORTS];
    int    cur_src [N_PORTS];
    int    cur_idx [N_PORTS];
    int    cur_len [N_PORTS];

    // ready held low in phase 0, random in 1, forced high in 2
    int    phase;
    int    srcs_done;
    int    pkts_stored;
    int    cycles;
    int    mismatches;
    int    other_errs;

    switch_top #(
        .NUM_PORTS (N_PORTS),
        .NUM_SLOTS (SLOTS)
    ) u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_sop  (wr_sop),
        .wr_eop  (wr_eop),
        .wr_vld  (wr_vld),
        .wr_data (wr_data),
        .wr_busy (wr_busy),
        .full    (full),
        .ready   (ready),
        .rd_sop  (rd_sop),
        .rd_eop  (rd_eop),
        .rd_vld  (rd_vld),
        .rd_data (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic report_mismatch(input string sig, input int port,
                                   input logic [31:0] got, input logic [31:0] exp);
        $display("MISMATCH %s[%0d] at %0t: got 0x%0h expected 0x%0h",
                 sig, port, $time, got, exp);
        mismatches++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        other_errs++;
    endtask

    function automatic bit queues_empty();
        for (int o = 0; o < N_PORTS; o++) begin
            for (int s = 0; s < N_PORTS; s++) begin
                if (exp_len[o][s].size() != 0 || exp_words[o][s].size() != 0) begin
                    return 1'b0;
                end
            end
        end
        return 1'b1;
    endfunction

    // random packets from one input port
    task automatic send_packets(input int src);
        hdr_word_u h;
        int        len;
        word_t     w;
        for (int n = 0; n < NUM_PKTS; n++) begin
            len        = 1 + int'($urandom % MAX_WORDS);
            h.hdr.seq  = 12'(n);
            h.hdr.src  = port_idx_t'(src);
            h.hdr.dest = port_idx_t'($urandom % N_PORTS);
            exp_len[h.hdr.dest][src].push_back(len);
            for (int k = 0; k < len; k++) begin
                w = (k == 0) ? h.raw : word_t'($urandom);
                exp_words[h.hdr.dest][src].push_back(w);
                wr_vld[src]  = 1'b1;
                wr_sop[src]  = (k == 0);
                wr_eop[src]  = (k == len - 1);
                wr_data[src] = w;
                next_cycle();
            end
            wr_vld[src] = 1'b0;
            wr_sop[src] = 1'b0;
            wr_eop[src] = 1'b0;
            while (wr_busy[src]) begin
                next_cycle();
            end
            pkts_stored++;
            repeat ($urandom % 3) next_cycle();
        end
        srcs_done++;
    endtask

    initial begin
        void'($urandom(32'h01e4dcb7));
        rst_n       = 1'b0;
        wr_sop      = '0;
        wr_eop      = '0;
        wr_vld      = '0;
        wr_data     = '0;
        ready       = '0;
        phase       = 0;
        srcs_done   = 0;
        pkts_stored = 0;
        mismatches  = 0;
        other_errs  = 0;
        for (int p = 0; p < N_PORTS; p++) begin
            in_pkt[p] = 1'b0;
        end
        repeat (3) @(posedge clk);
        #5;
        rst_n = 1'b1;
        if (full || wr_busy != '0 || rd_vld != '0) begin
            report_error("outputs not idle after reset");
        end
        for (int i = 0; i < N_PORTS; i++) begin
            fork
                automatic int k = i;
                send_packets(k);
            join_none
        end
        // outputs held off until the buffer fills
        while (!full) begin
            next_cycle();
        end
        repeat (10) next_cycle();
        if (pkts_stored != SLOTS) begin
            report_error($sformatf("buffer full after %0d stored packets instead of %0d",
                                   pkts_stored, SLOTS));
        end
        repeat (10) begin
            if (!full) begin
                report_error("full dropped while all outputs were held off");
            end
            if (wr_busy == '0) begin
                report_error("no input held busy while the buffer was full");
            end
            next_cycle();
        end
        phase = 1;
        while (srcs_done != N_PORTS) begin
            next_cycle();
        end
        phase = 2;
        while (!queues_empty()) begin
            next_cycle();
        end
        repeat (20) next_cycle();
        if (full) begin
            report_mismatch("full", 0, 32'(full), 32'd0);
        end
        if (wr_busy != '0) begin
            report_mismatch("wr_busy", 0, 32'(wr_busy), 32'd0);
        end
        $display("checks done: %0d mismatches, %0d other errors", mismatches, other_errs);
        if (mismatches + other_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        forever begin
            next_cycle();
            if (phase == 1) begin
                ready = N_PORTS'($urandom);
            end else begin
                ready = (phase == 2) ? '1 : '0;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= (rst_n) ? cycles + 1 : 0;
        if (cycles == TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // output monitor on the falling edge
    always @(negedge clk) begin : monitor
        hdr_word_u h;
        word_t     exp_w;
        if (rst_n) begin
            for (int p = 0; p < N_PORTS; p++) begin
                if ((rd_sop[p] || rd_eop[p]) && !rd_vld[p]) begin
                    report_error($sformatf("sop or eop without rd_vld on output %0d", p));
                end
                if (rd_vld[p] && phase == 0) begin
                    report_error($sformatf("output %0d sent data while ready was low", p));
                end
                if (!rd_vld[p]) begin
                    if (in_pkt[p]) begin
                        report_error($sformatf("gap inside a packet on output %0d", p));
                        in_pkt[p] = 1'b0;
                    end
                end else begin
                    if (!in_pkt[p]) begin
                        h.raw = rd_data[p];
                        if (!rd_sop[p]) begin
                            report_mismatch("rd_sop", p, 32'd0, 32'd1);
                        end
                        if (h.hdr.dest != port_idx_t'(p)) begin
                            report_mismatch("dest", p, 32'(h.hdr.dest), 32'(p));
                        end
                        cur_src[p] = int'(h.hdr.src);
                        cur_idx[p] = 0;
                        in_pkt[p]  = 1'b1;
                        if (exp_len[p][cur_src[p]].size() == 0) begin
                            report_error($sformatf("unexpected packet on output %0d from %0d",
                                                   p, cur_src[p]));
                            cur_len[p] = 0;
                        end else begin
                            cur_len[p] = exp_len[p][cur_src[p]].pop_front();
                        end
                    end else if (rd_sop[p]) begin
                        report_mismatch("rd_sop", p, 32'd1, 32'd0);
                    end
                    if (cur_idx[p] < cur_len[p]) begin
                        exp_w = exp_words[p][cur_src[p]].pop_front();
                        if (rd_data[p] != exp_w) begin
                            report_mismatch("rd_data", p, 32'(rd_data[p]), 32'(exp_w));
                        end
                        if (rd_eop[p] != (cur_idx[p] == cur_len[p] - 1)) begin
                            report_mismatch("rd_eop", p, 32'(rd_eop[p]),
                                            32'(cur_idx[p] == cur_len[p] - 1));
                        end
                    end
                    cur_idx[p]++;
                    if (rd_eop[p]) begin
                        in_pkt[p] = 1'b0;
                        if (cur_len[p] != 0 && cur_idx[p] != cur_len[p]) begin
                            report_mismatch("length", p, cur_idx[p], cur_len[p]);
                        end
                        // skip the words a short packet never sent
                        while (cur_idx[p] < cur_len[p]) begin
                            void'(exp_words[p][cur_src[p]].pop_front());
                            cur_idx[p]++;
                        end
                    end
                end
            end
        end
    end

endmodule

/* testbench/switch_chk.sv */
`timescale 1ns/100ps

module arb_chk #(
    parameter int NUM_PORTS = 4
) (
    input logic                 clk,
    input logic                 rst_n,
    input logic [NUM_PORTS-1:0] req,
    input logic [NUM_PORTS-1:0] gnt
);

    gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt))
        else $error("arbiter grant is not one-hot");

    // a fresh grant goes to a port that requested
    gnt_to_req: assert property (@(posedge clk) disable iff (!rst_n)
        ((|gnt) && !(|$past(gnt))) |-> (|(gnt & $past(req))))
        else $error("arbiter granted a port without a request");

    gnt_held: assert property (@(posedge clk) disable iff (!rst_n)
        (|(gnt & req)) |=> (gnt == $past(gnt)))
        else $error("arbiter grant changed while its owner still requested");

endmodule

bind rr_arbiter arb_chk #(.NUM_PORTS(NUM_PORTS)) u_arb_chk (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .gnt   (gnt)
);

/* design/switch_top.sv */
`timescale 1ns/100ps

module switch_top #(
    parameter int NUM_PORTS = switch_pkg::N_PORTS,
    parameter int NUM_SLOTS = switch_pkg::SLOTS
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [NUM_PORTS-1:0]                wr_sop,
    input  logic [NUM_PORTS-1:0]                wr_eop,
    input  logic [NUM_PORTS-1:0]                wr_vld,
    input  switch_pkg::word_t [NUM_PORTS-1:0]   wr_data,
    output logic [NUM_PORTS-1:0]                wr_busy,
    output logic                                full,
    input  logic [NUM_PORTS-1:0]                ready,
    output logic [NUM_PORTS-1:0]                rd_sop,
    output logic [NUM_PORTS-1:0]                rd_eop,
    output logic [NUM_PORTS-1:0]                rd_vld,
    output switch_pkg::word_t [NUM_PORTS-1:0]   rd_data
);

    buf_wr_if wr_bus [NUM_PORTS] ();
    buf_rd_if rd_bus [NUM_PORTS] ();

    logic [NUM_PORTS-1:0] wr_req;
    logic [NUM_PORTS-1:0] wr_gnt;
    logic [NUM_PORTS-1:0] rd_req;
    logic [NUM_PORTS-1:0] rd_gnt;
    logic                 slot_free;
    logic                 rd_idle;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        // request and grant bits between buses and arbiters
        assign wr_req[p]      = wr_bus[p].req;
        assign wr_bus[p].gnt  = wr_gnt[p];
        assign rd_req[p]      = rd_bus[p].req;
        assign rd_bus[p].gnt  = rd_gnt[p];

        wr_frontend u_wr_fe (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_sop  (wr_sop[p]),
            .wr_eop  (wr_eop[p]),
            .wr_vld  (wr_vld[p]),
            .wr_data (wr_data[p]),
            .wr_busy (wr_busy[p]),
            .bus     (wr_bus[p])
        );

        rd_frontend u_rd_fe (
            .clk     (clk),
            .rst_n   (rst_n),
            .ready   (ready[p]),
            .rd_sop  (rd_sop[p]),
            .rd_eop  (rd_eop[p]),
            .rd_vld  (rd_vld[p]),
            .rd_data (rd_data[p]),
            .bus     (rd_bus[p])
        );
    end

    // write grants only while a slot is free
    rr_arbiter #(.NUM_PORTS(NUM_PORTS)) u_wr_arb (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (wr_req),
        .allow (slot_free),
        .gnt   (wr_gnt)
    );

    rr_arbiter #(.NUM_PORTS(NUM_PORTS)) u_rd_arb (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (rd_req),
        .allow (rd_idle),
        .gnt   (rd_gnt)
    );

    packet_buffer #(
        .NUM_PORTS (NUM_PORTS),
        .NUM_SLOTS (NUM_SLOTS)
    ) u_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (wr_bus),
        .rd        (rd_bus),
        .slot_free (slot_free),
        .rd_idle   (rd_idle),
        .full      (full)
    );

endmodule

/* design/packet_buffer.sv */
`timescale 1ns/100ps

module packet_buffer #(
    parameter int NUM_PORTS = switch_pkg::N_PORTS,
    parameter int NUM_SLOTS = switch_pkg::SLOTS
) (
    input  logic     clk,
    input  logic     rst_n,
    buf_wr_if.buffer wr [NUM_PORTS],
    buf_rd_if.buffer rd [NUM_PORTS],
    output logic     slot_free,
    output logic     rd_idle,
    output logic     full
);
    import switch_pkg::*;

    localparam int IDX_W = $clog2(MAX_WORDS);
    localparam int CNT_W = $clog2(NUM_SLOTS) + 1;

    word_t                mem [NUM_SLOTS*MAX_WORDS];
    logic [NUM_SLOTS-1:0] free_map;

    // per-output descriptor queues
    slot_idx_t  q_slot [NUM_PORTS][NUM_SLOTS];
    len_t       q_len  [NUM_PORTS][NUM_SLOTS];
    slot_idx_t  q_head [NUM_PORTS];
    slot_idx_t  q_tail [NUM_PORTS];
    logic [CNT_W-1:0] q_cnt [NUM_PORTS];
    logic [NUM_PORTS-1:0] q_push;
    logic [NUM_PORTS-1:0] q_pop;

    logic [NUM_PORTS-1:0] w_gnt;
    logic [NUM_PORTS-1:0] w_vld;
    logic [NUM_PORTS-1:0] w_last;
    logic [NUM_PORTS-1:0] r_gnt;
    word_t                w_data [NUM_PORTS];

    // write side
    hdr_word_u w_word;
    logic      w_en;
    logic      w_end;
    logic      wr_first_q;
    slot_idx_t low_free;
    slot_idx_t w_slot;
    slot_idx_t wr_slot_q;
    len_t      w_idx;
    len_t      wr_cnt_q;
    port_idx_t w_dest;
    port_idx_t wr_dest_q;

    // read side
    logic      rd_owned;
    logic      rd_active;
    logic      rd_start;
    logic      rd_end;
    logic      rd_vld_q;
    logic      rd_last_q;
    port_idx_t r_port;
    port_idx_t rd_port_q;
    slot_idx_t rd_slot_q;
    len_t      rd_len_q;
    len_t      rd_cnt_q;
    word_t     rd_data_q;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_bus
        assign w_gnt[p]    = wr[p].gnt;
        assign w_vld[p]    = wr[p].vld;
        assign w_last[p]   = wr[p].last;
        assign w_data[p]   = wr[p].data;
        assign r_gnt[p]    = rd[p].gnt;
        assign q_push[p]   = w_end && (w_dest == port_idx_t'(p));
        assign q_pop[p]    = rd_start && (r_port == port_idx_t'(p));
        assign rd[p].avail = q_cnt[p] != '0;
        assign rd[p].vld   = rd_vld_q && (rd_port_q == port_idx_t'(p));
        assign rd[p].data  = rd_data_q;
        assign rd[p].last  = rd_last_q;
    end

    // granted writer and granted reader
    always_comb begin
        w_word.raw = '0;
        r_port     = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (w_gnt[p]) begin
                w_word.raw = w_data[p];
            end
            if (r_gnt[p]) begin
                r_port = port_idx_t'(p);
            end
        end
    end

    // lowest free slot
    always_comb begin
        low_free = '0;
        for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
            if (free_map[s]) begin
                low_free = slot_idx_t'(s);
            end
        end
    end

    assign w_en   = |(w_gnt & w_vld);
    assign w_end  = |(w_gnt & w_vld & w_last);
    assign w_slot = wr_first_q ? low_free : wr_slot_q;
    assign w_idx  = wr_first_q ? '0 : wr_cnt_q;
    // header view of the first word picks the output
    assign w_dest = wr_first_q ? w_word.hdr.dest : wr_dest_q;

    assign rd_start = !rd_owned && (|r_gnt);
    assign rd_end   = rd_active && (rd_cnt_q + 1'b1 == rd_len_q);

    always_ff @(posedge clk) begin
        if (w_en) begin
            mem[{w_slot, w_idx[IDX_W-1:0]}] <= w_word.raw;
            wr_slot_q <= w_slot;
            wr_cnt_q  <= w_idx + 1'b1;
            wr_dest_q <= w_dest;
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (q_push[p]) begin
                q_slot[p][q_tail[p]] <= w_slot;
                q_len[p][q_tail[p]]  <= w_idx + 1'b1;
            end
        end
        if (rd_start) begin
            rd_port_q <= r_port;
            rd_slot_q <= q_slot[r_port][q_head[r_port]];
            rd_len_q  <= q_len[r_port][q_head[r_port]];
        end
        // data one cycle after its address
        if (rd_active) begin
            rd_data_q <= mem[{rd_slot_q, rd_cnt_q[IDX_W-1:0]}];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_first_q <= 1'b1;
            free_map   <= '1;
            rd_owned   <= 1'b0;
            rd_active  <= 1'b0;
            rd_cnt_q   <= '0;
            rd_vld_q   <= 1'b0;
            rd_last_q  <= 1'b0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                q_head[p] <= '0;
                q_tail[p] <= '0;
                q_cnt[p]  <= '0;
            end
        end else begin
            if (w_en) begin
                wr_first_q <= w_end;
                if (wr_first_q) begin
                    free_map[low_free] <= 1'b0;
                end
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (q_push[p]) begin
                    q_tail[p] <= q_tail[p] + 1'b1;
                end
                if (q_pop[p]) begin
                    q_head[p] <= q_head[p] + 1'b1;
                end
                if (q_push[p] != q_pop[p]) begin
                    q_cnt[p] <= q_push[p] ? q_cnt[p] + 1'b1 : q_cnt[p] - 1'b1;
                end
            end
            // keep ownership until the arbiter lets go
            if (rd_start) begin
                rd_owned  <= 1'b1;
                rd_active <= 1'b1;
                rd_cnt_q  <= '0;
            end else if (rd_owned && !rd_active && !r_gnt[rd_port_q]) begin
                rd_owned <= 1'b0;
            end
            if (rd_active) begin
                rd_cnt_q <= rd_cnt_q + 1'b1;
                if (rd_end) begin
                    rd_active          <= 1'b0;
                    free_map[rd_slot_q] <= 1'b1;
                end
            end
            rd_vld_q  <= rd_active;
            rd_last_q <= rd_end;
        end
    end

    assign slot_free = |free_map;
    assign full      = ~slot_free;
    assign rd_idle   = !rd_active && !rd_vld_q;

endmodule

/* design/rd_frontend.sv */
`timescale 1ns/100ps

module rd_frontend (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ready,
    output logic              rd_sop,
    output logic              rd_eop,
    output logic              rd_vld,
    output switch_pkg::word_t rd_data,
    buf_rd_if.frontend        bus
);

    logic req_q;
    logic in_pkt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q  <= 1'b0;
            in_pkt <= 1'b0;
        end else begin
            // ready only matters before the packet starts
            if (bus.vld && bus.last) begin
                req_q <= 1'b0;
            end else if (!req_q && ready && bus.avail) begin
                req_q <= 1'b1;
            end
            if (bus.vld) begin
                in_pkt <= !bus.last;
            end
        end
    end

    assign bus.req = req_q;

    // words pass straight through, framing added here
    assign rd_vld  = bus.vld;
    assign rd_data = bus.data;
    assign rd_sop  = bus.vld && !in_pkt;
    assign rd_eop  = bus.vld && bus.last;

endmodule

/* design/wr_frontend.sv */
`timescale 1ns/100ps

module wr_frontend (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_sop,
    input  logic              wr_eop,
    input  logic              wr_vld,
    input  switch_pkg::word_t wr_data,
    output logic              wr_busy,
    buf_wr_if.frontend        bus
);
    import switch_pkg::*;

    localparam int IDX_W = $clog2(MAX_WORDS);

    word_t stage [MAX_WORDS];
    len_t  len_q;
    len_t  in_cnt;
    len_t  out_cnt;
    len_t  wr_ptr;
    logic  pending;
    logic  sending;
    logic  last_word;

    // sop restarts the fill position
    assign wr_ptr = wr_sop ? '0 : in_cnt;

    // staging words and length
    always_ff @(posedge clk) begin
        if (wr_vld && !pending) begin
            stage[wr_ptr[IDX_W-1:0]] <= wr_data;
            if (wr_eop) begin
                len_q <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_cnt  <= '0;
            out_cnt <= '0;
            pending <= 1'b0;
            sending <= 1'b0;
        end else begin
            if (wr_vld && !pending) begin
                in_cnt <= wr_ptr + 1'b1;
                if (wr_eop) begin
                    pending <= 1'b1;
                end
            end
            // burst starts the cycle after the grant
            if (pending && bus.gnt && !sending) begin
                sending <= 1'b1;
                out_cnt <= '0;
            end else if (sending) begin
                out_cnt <= out_cnt + 1'b1;
                if (last_word) begin
                    sending <= 1'b0;
                    pending <= 1'b0;
                end
            end
        end
    end

    assign last_word = sending && (out_cnt + 1'b1 == len_q);

    assign wr_busy  = pending;
    assign bus.req  = pending;
    assign bus.vld  = sending;
    assign bus.data = stage[out_cnt[IDX_W-1:0]];
    assign bus.last = last_word;

endmodule

/* design/rr_arbiter.sv */
`timescale 1ns/100ps

module rr_arbiter #(
    parameter int NUM_PORTS = switch_pkg::N_PORTS
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_PORTS-1:0] req,
    input  logic                 allow,
    output logic [NUM_PORTS-1:0] gnt
);

    localparam int IDX_W = $clog2(NUM_PORTS);

    logic [NUM_PORTS-1:0] gnt_q;
    logic [IDX_W-1:0]     last_q;
    logic [IDX_W-1:0]     cand;
    logic [IDX_W-1:0]     pick_idx;
    logic                 pick_vld;

    // first requester after the previous winner
    always_comb begin
        pick_vld = 1'b0;
        pick_idx = last_q;
        cand     = last_q;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            cand = IDX_W'((int'(last_q) + k) % NUM_PORTS);
            if (!pick_vld && req[cand]) begin
                pick_vld = 1'b1;
                pick_idx = cand;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gnt_q  <= '0;
            // port 0 wins first after reset
            last_q <= IDX_W'(NUM_PORTS - 1);
        end else if (|gnt_q) begin
            // owner dropped req, burst done
            if (!(|(gnt_q & req))) begin
                gnt_q <= '0;
            end
        end else if (allow && pick_vld) begin
            gnt_q  <= NUM_PORTS'(1) << pick_idx;
            last_q <= pick_idx;
        end
    end

    assign gnt = gnt_q;

endmodule

/* design/buf_rd_if.sv */
`timescale 1ns/100ps

interface buf_rd_if;
    import switch_pkg::*;

    logic  req;
    logic  gnt;
    // descriptor queue of this output not empty
    logic  avail;

    // registered read data from the buffer
    logic  vld;
    word_t data;
    logic  last;

    modport frontend (
        output req,
        input  avail,
        input  vld,
        input  data,
        input  last
    );

    modport buffer (
        input  gnt,
        output avail,
        output vld,
        output data,
        output last
    );

endinterface

/* design/buf_wr_if.sv */
`timescale 1ns/100ps

interface buf_wr_if;
    import switch_pkg::*;

    // burst request, held until the word after last
    logic  req;
    logic  gnt;

    // one word per cycle while vld is high
    logic  vld;
    word_t data;
    logic  last;

    modport frontend (
        output req,
        output vld,
        output data,
        output last,
        input  gnt
    );

    modport buffer (
        input gnt,
        input vld,
        input data,
        input last
    );

endinterface

/* design/switch_pkg.sv */
package switch_pkg;

    // port count and buffer geometry
    parameter int N_PORTS   = 4;
    parameter int MAX_WORDS = 8;
    parameter int SLOTS     = 8;
    parameter int DATA_W    = 16;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [1:0]        port_idx_t;
    typedef logic [2:0]        slot_idx_t;
    // packet length, 0 to MAX_WORDS
    typedef logic [3:0]        len_t;

    // layout of the first word of every packet
    typedef struct packed {
        logic [11:0] seq;
        port_idx_t   src;
        port_idx_t   dest;
    } hdr_t;

    // same word, seen as data or as header
    typedef union packed {
        word_t raw;
        hdr_t  hdr;
    } hdr_word_u;

endpackage
